/* src.f */
hw/ifm_pool_pkg.sv
hw/ifm_bank.sv
hw/ifm_write_ctrl.sv
hw/pool_read_ctrl.sv
hw/max_pool_unit.sv
hw/ifm_mem_array.sv
hw/ifm_pool_top.sv
tests/tb_ifm_pool_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ifm_pool_top -f src.f

output=$(./obj_dir/Vtb_ifm_pool_top)
echo "$output"

if echo "$output" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1

/* tests/tb_ifm_pool_top.sv */
`timescale 1ns/1ps

module tb_ifm_pool_top;

	localparam int UNITS = ifm_pool_pkg::DEFAULT_UNITS;
	localparam int SIZE = ifm_pool_pkg::DEFAULT_IFM_SIZE;
	localparam int PIXELS = SIZE * SIZE;
	localparam int PAIRS = PIXELS / 2;
	localparam int FRAMES = 3;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_GAP = 3;
	localparam int CYCLE_LIMIT = RESET_CYCLES + FRAMES * (32 + PIXELS * MAX_GAP) + 200;

	typedef ifm_pool_pkg::pixel_t [UNITS-1:0] lanes_t;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	lanes_t in_pixels;
	logic   busy;
	logic   out_valid;
	lanes_t out_pixels;

	logic [15:0] lfsr_state = 16'd36;
	lanes_t      frame_px [PIXELS];
	lanes_t      expected_q [$];
	lanes_t      expected_head;
	logic        have_expect;
	logic        frame_seen;
	logic        in_run;
	int          run_len;
	int          results_seen;
	int          errors;
	int          cycles;

	ifm_pool_top #(
		.NUMBER_OF_UNITS(UNITS),
		.IFM_SIZE(SIZE)
	) dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_pixels  (in_pixels),
		.busy       (busy),
		.out_valid  (out_valid),
		.out_pixels (out_pixels)
	);

	always #10 clk = ~clk;

	// ****************************************
	// Random source
	// ****************************************

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	task automatic random_lanes(output lanes_t lanes);
		logic [15:0] r;
		for (int u = 0; u < UNITS; u++)
		begin
			draw_bits(16, r);
			lanes[u] = r;
		end
	endtask

	// ****************************************
	// Stimulus and reference model
	// ****************************************

	task automatic send_frame();
		logic [15:0] r;
		lanes_t      e;
		for (int p = 0; p < PIXELS; p++)
		begin
			draw_bits(2, r);
			repeat (r[1:0]) @(negedge clk);
			random_lanes(frame_px[p]);
			in_pixels = frame_px[p];
			in_valid = 1'b1;
			if (p == PIXELS - 1)
			begin
				frame_seen = 1'b1;
			end
			@(negedge clk);
			in_valid = 1'b0;
		end
		for (int k = 0; k < PAIRS; k++)
		begin
			for (int u = 0; u < UNITS; u++)
			begin
				e[u] = (frame_px[2*k][u] > frame_px[2*k+1][u]) ?
					frame_px[2*k][u] : frame_px[2*k+1][u];
			end
			expected_q.push_back(e);
		end
	endtask

	// These strobes must not reach the banks
	task automatic drop_strobes_while_busy();
		logic [15:0] r;
		lanes_t      junk;
		while (!busy)
			@(negedge clk);
		draw_bits(2, r);
		for (int i = 0; i <= int'(r[1:0]); i++)
		begin
			random_lanes(junk);
			in_pixels = junk;
			in_valid = 1'b1;
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	// Load the expected result for each out_valid cycle
	always @(negedge clk)
	begin
		if (out_valid)
		begin
			run_len = in_run ? run_len + 1 : 1;
			in_run = 1'b1;
			results_seen++;
			if (expected_q.size() == 0)
			begin
				have_expect = 1'b0;
				errors++;
				$display("Result arrived at %0t with no frame left to pool", $time);
			end
			else
			begin
				expected_head = expected_q.pop_front();
				have_expect = 1'b1;
			end
		end
		else
		begin
			in_run = 1'b0;
		end
	end

	// ****************************************
	// Checks
	// ****************************************

	a_idle_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!frame_seen |-> !busy)
	else
	begin
		errors++;
		$display("** Error at %0t: busy = %b, expected 0", $time, $sampled(busy));
	end

	a_idle_out_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!frame_seen |-> !out_valid)
	else
	begin
		errors++;
		$display("** Error at %0t: out_valid = %b, expected 0", $time, $sampled(out_valid));
	end

	a_pool_max: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && have_expect) |-> (out_pixels == expected_head))
	else
	begin
		errors++;
		$display("** Error at %0t: out_pixels = %h, expected %h", $time,
			$sampled(out_pixels), expected_head);
	end

	a_valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> busy)
	else
	begin
		errors++;
		$display("** Error at %0t: busy = %b, expected 1", $time, $sampled(busy));
	end

	a_run_length: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> (run_len == PAIRS))
	else
	begin
		errors++;
		$display("** Error at %0t: out_valid run length = %0d, expected %0d", $time,
			run_len, PAIRS);
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the frames did not finish", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_pixels = '0;
		expected_head = '0;
		have_expect = 1'b0;
		frame_seen = 1'b0;
		in_run = 1'b0;
		run_len = 0;
		results_seen = 0;
		errors = 0;
		cycles = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (int f = 0; f < FRAMES; f++)
		begin
			send_frame();
			drop_strobes_while_busy();
			while (busy)
				@(negedge clk);
		end
		repeat (4) @(negedge clk);
		if (results_seen != FRAMES * PAIRS)
		begin
			errors++;
			$display("Saw %0d pooled results, expected %0d", results_seen, FRAMES * PAIRS);
		end
		if (expected_q.size() != 0)
		begin
			errors++;
			$display("%0d expected results were never produced", expected_q.size());
		end
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* hw/ifm_pool_top.sv */
`timescale 1ns/1ps

module ifm_pool_top #(
	parameter int NUMBER_OF_UNITS = ifm_pool_pkg::DEFAULT_UNITS,
	parameter int IFM_SIZE = ifm_pool_pkg::DEFAULT_IFM_SIZE,
	localparam int ADDR_WIDTH = $clog2(IFM_SIZE * IFM_SIZE)
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        in_valid,
	input  ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  in_pixels,
	output logic                                        busy,
	output logic                                        out_valid,
	output ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  out_pixels
);

	logic                                       wr_en;
	logic [ADDR_WIDTH-1:0]                      wr_addr;
	logic                                       frame_done;
	logic                                       rd_en;
	logic [ADDR_WIDTH-1:0]                      rd_addr_a;
	logic [ADDR_WIDTH-1:0]                      rd_addr_b;
	logic                                       rd_valid;
	ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0] pix_a;
	ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0] pix_b;

	// ****************************************
	// Previous layer side
	// ****************************************

	ifm_write_ctrl #(
		.IFM_SIZE(IFM_SIZE)
	) write_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.busy       (busy),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.frame_done (frame_done)
	);

	ifm_mem_array #(
		.NUMBER_OF_UNITS(NUMBER_OF_UNITS),
		.IFM_SIZE(IFM_SIZE)
	) mem_array_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_pixels (in_pixels),
		.rd_en     (rd_en),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.pix_a     (pix_a),
		.pix_b     (pix_b),
		.rd_valid  (rd_valid)
	);

	// ****************************************
	// Pooling side
	// ****************************************

	pool_read_ctrl #(
		.IFM_SIZE(IFM_SIZE)
	) read_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame_done (frame_done),
		.rd_en      (rd_en),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.busy       (busy)
	);

	max_pool_unit #(
		.NUMBER_OF_UNITS(NUMBER_OF_UNITS)
	) pool_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_a      (pix_a),
		.pix_b      (pix_b),
		.rd_valid   (rd_valid),
		.out_valid  (out_valid),
		.out_pixels (out_pixels)
	);

endmodule

/* hw/ifm_mem_array.sv */
`timescale 1ns/1ps

module ifm_mem_array #(
	parameter int NUMBER_OF_UNITS = ifm_pool_pkg::DEFAULT_UNITS,
	parameter int IFM_SIZE = ifm_pool_pkg::DEFAULT_IFM_SIZE,
	localparam int ADDR_WIDTH = $clog2(IFM_SIZE * IFM_SIZE)
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        wr_en,
	input  logic [ADDR_WIDTH-1:0]                       wr_addr,
	input  ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  wr_pixels,
	input  logic                                        rd_en,
	input  logic [ADDR_WIDTH-1:0]                       rd_addr_a,
	input  logic [ADDR_WIDTH-1:0]                       rd_addr_b,
	output ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  pix_a,
	output ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  pix_b,
	output logic                                        rd_valid
);

	logic [ADDR_WIDTH-1:0] addr_a;

	// Shared port A address for writes and pooling reads
	assign addr_a = wr_en ? wr_addr : rd_addr_a;

	// Bank read latency is one cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_en;
		end
	end

	// ****************************************
	// One bank per processing unit
	// ****************************************

	for (genvar u = 0; u < NUMBER_OF_UNITS; u++)
	begin : g_bank
		ifm_bank #(
			.IFM_SIZE(IFM_SIZE)
		) bank_i (
			.clk       (clk),
			.wr_en_a   (wr_en),
			.addr_a    (addr_a),
			.wr_data_a (wr_pixels[u]),
			.rd_en     (rd_en),
			.addr_b    (rd_addr_b),
			.rd_data_a (pix_a[u]),
			.rd_data_b (pix_b[u])
		);
	end

endmodule

/* hw/max_pool_unit.sv */
`timescale 1ns/1ps

module max_pool_unit #(
	parameter int NUMBER_OF_UNITS = ifm_pool_pkg::DEFAULT_UNITS
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  pix_a,
	input  ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  pix_b,
	input  logic                                        rd_valid,
	output logic                                        out_valid,
	output ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0]  out_pixels
);

	ifm_pool_pkg::pixel_t [NUMBER_OF_UNITS-1:0] lane_max;

	// Unsigned compare per lane
	always_comb
	begin
		for (int u = 0; u < NUMBER_OF_UNITS; u++)
		begin
			lane_max[u] = (pix_a[u] >= pix_b[u]) ? pix_a[u] : pix_b[u];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_valid)
		begin
			out_pixels <= lane_max;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= rd_valid;
		end
	end

endmodule

/* hw/pool_read_ctrl.sv */
`timescale 1ns/1ps

module pool_read_ctrl #(
	parameter int IFM_SIZE = ifm_pool_pkg::DEFAULT_IFM_SIZE,
	localparam int ADDR_WIDTH = $clog2(IFM_SIZE * IFM_SIZE)
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  frame_done,
	output logic                  rd_en,
	output logic [ADDR_WIDTH-1:0] rd_addr_a,
	output logic [ADDR_WIDTH-1:0] rd_addr_b,
	output logic                  busy
);

	localparam int PAIR_WIDTH = ADDR_WIDTH - 1;
	localparam int NUM_PAIRS = IFM_SIZE * IFM_SIZE / 2;
	localparam logic [PAIR_WIDTH-1:0] LAST_PAIR = PAIR_WIDTH'(NUM_PAIRS - 1);

	ifm_pool_pkg::pool_state_e state;
	ifm_pool_pkg::pool_state_e state_next;
	logic [PAIR_WIDTH-1:0]     pair_idx;
	logic                      drain_cnt;

	// ****************************************
	// Next state
	// ****************************************

	always_comb
	begin
		state_next = state;
		case (state)
			ifm_pool_pkg::POOL_IDLE:
			begin
				if (frame_done)
				begin
					state_next = ifm_pool_pkg::POOL_READ;
				end
			end
			ifm_pool_pkg::POOL_READ:
			begin
				if (pair_idx == LAST_PAIR)
				begin
					state_next = ifm_pool_pkg::POOL_DRAIN;
				end
			end
			ifm_pool_pkg::POOL_DRAIN:
			begin
				// Bank read and pooling register both empty
				if (drain_cnt)
				begin
					state_next = ifm_pool_pkg::POOL_IDLE;
				end
			end
			default:
			begin
				state_next = ifm_pool_pkg::POOL_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= ifm_pool_pkg::POOL_IDLE;
			pair_idx  <= '0;
			drain_cnt <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state == ifm_pool_pkg::POOL_READ)
			begin
				pair_idx <= (pair_idx == LAST_PAIR) ? '0 : pair_idx + 1'b1;
			end
			if (state == ifm_pool_pkg::POOL_DRAIN)
			begin
				drain_cnt <= !drain_cnt;
			end
		end
	end

	assign rd_en = (state == ifm_pool_pkg::POOL_READ);
	assign busy = (state != ifm_pool_pkg::POOL_IDLE);

	// Neighbouring pixels 2k and 2k+1
	assign rd_addr_a = {pair_idx, 1'b0};
	assign rd_addr_b = {pair_idx, 1'b1};

endmodule

/* hw/ifm_write_ctrl.sv */
`timescale 1ns/1ps

module ifm_write_ctrl #(
	parameter int IFM_SIZE = ifm_pool_pkg::DEFAULT_IFM_SIZE,
	localparam int ADDR_WIDTH = $clog2(IFM_SIZE * IFM_SIZE)
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  busy,
	output logic                  wr_en,
	output logic [ADDR_WIDTH-1:0] wr_addr,
	output logic                  frame_done
);

	localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(IFM_SIZE * IFM_SIZE - 1);

	// Strobes during pooling are dropped
	assign wr_en = in_valid && !busy;

	// Row-major write pointer that wraps at the end of the frame
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_addr    <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			if (wr_en)
			begin
				if (wr_addr == LAST_ADDR)
				begin
					wr_addr    <= '0;
					frame_done <= 1'b1;
				end
				else
				begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end
	end

endmodule

/* hw/ifm_bank.sv */
`timescale 1ns/1ps

module ifm_bank #(
	parameter int IFM_SIZE = ifm_pool_pkg::DEFAULT_IFM_SIZE,
	localparam int ADDR_WIDTH = $clog2(IFM_SIZE * IFM_SIZE)
) (
	input  logic                  clk,
	input  logic                  wr_en_a,
	input  logic [ADDR_WIDTH-1:0] addr_a,
	input  ifm_pool_pkg::pixel_t  wr_data_a,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] addr_b,
	output ifm_pool_pkg::pixel_t  rd_data_a,
	output ifm_pool_pkg::pixel_t  rd_data_b
);

	localparam int DEPTH = IFM_SIZE * IFM_SIZE;

	ifm_pool_pkg::pixel_t mem [0:DEPTH-1];

	// Port A writes from the previous layer or reads for pooling
	always_ff @(posedge clk)
	begin
		if (wr_en_a)
		begin
			mem[addr_a] <= wr_data_a;
		end
		else if (rd_en)
		begin
			rd_data_a <= mem[addr_a];
		end
	end

	// Port B is read only
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data_b <= mem[addr_b];
		end
	end

endmodule

/* hw/ifm_pool_pkg.sv */
package ifm_pool_pkg;

	// ****************************************
	// Pixel format
	// ****************************************

	// Unsigned feature map value
	localparam int PIXEL_WIDTH = 16;

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;

	// ****************************************
	// Default geometry
	// ****************************************

	localparam int DEFAULT_UNITS = 4;

	// Even side length keeps each pair inside one row
	localparam int DEFAULT_IFM_SIZE = 4;

	// Read controller states
	typedef enum logic [1:0]
	{
		POOL_IDLE,
		POOL_READ,
		POOL_DRAIN
	} pool_state_e;

endpackage
